//--- hw/soc_bus_pkg.sv
package soc_bus_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // one memory select plus one per multiplier
  localparam int num_mult = 4;
  localparam int num_cs = num_mult + 1;

  // upper address half picks the block
  localparam int page_w = 16;
  localparam logic [page_w-1:0] mult_page_base = 16'h0040;

  // data memory geometry
  localparam int ram_words = 256;
  localparam int ram_aw = 8;
  // word index plus byte lane bits
  localparam int sel_w = ram_aw + 2;

  // multiplier register map
  localparam int reg_aw = 5;
  localparam logic [reg_aw-1:0] reg_op_a = 5'd0;
  localparam logic [reg_aw-1:0] reg_op_b = 5'd4;
  localparam logic [reg_aw-1:0] reg_init = 5'd8;
  localparam logic [reg_aw-1:0] reg_result = 5'd12;
  localparam logic [reg_aw-1:0] reg_done = 5'd16;

  // shift-add engine
  localparam int op_w = 16;
  localparam int mult_steps = 16;
  localparam int step_w = $clog2(mult_steps);
  localparam logic [step_w-1:0] last_step = step_w'(mult_steps - 1);

  // same address word, read as memory index or as peripheral register
  typedef union packed {
    struct packed {
      logic [page_w-1:0] page;
      logic [addr_w-page_w-sel_w-1:0] pad;
      logic [ram_aw-1:0] index;
      logic [1:0] lane;
    } mem_view;
    struct packed {
      logic [page_w-1:0] page;
      logic [addr_w-page_w-reg_aw-1:0] pad;
      logic [reg_aw-1:0] offset;
    } per_view;
  } bus_addr_u;

endpackage

//--- hw/periph_bus_if.sv
interface periph_bus_if;

  // per-block select
  logic cs;
  // shared strobes
  logic rd;
  logic wr;
  logic [3:0] wmask;
  // memory index or register offset, zero-extended
  logic [soc_bus_pkg::sel_w-1:0] reg_sel;
  logic [soc_bus_pkg::data_w-1:0] wdata;
  // registered read data of this block
  logic [soc_bus_pkg::data_w-1:0] rdata;

  // decoder side
  modport host (
    output cs,
    output rd,
    output wr,
    output wmask,
    output reg_sel,
    output wdata
  );

  // memory and peripherals
  modport target (
    input  cs,
    input  rd,
    input  wr,
    input  wmask,
    input  reg_sel,
    input  wdata,
    output rdata
  );

  // read mux only needs select and data
  modport sink (
    input cs,
    input rdata
  );

endinterface

//--- hw/address_decoder.sv
module address_decoder (
  input  logic [soc_bus_pkg::addr_w-1:0] mem_addr,
  input  logic [soc_bus_pkg::data_w-1:0] mem_wdata,
  input  logic [3:0]                     mem_wmask,
  input  logic                           mem_rstrb,
  periph_bus_if.host                     blk [soc_bus_pkg::num_cs]
);

  soc_bus_pkg::bus_addr_u addr;
  logic [soc_bus_pkg::num_cs-1:0] cs;

  assign addr = mem_addr;

  always_comb begin
    cs = '0;
    // one page per multiplier, starting at the base page
    for (int i = 0; i < soc_bus_pkg::num_mult; i++) begin
      if (addr.per_view.page == soc_bus_pkg::mult_page_base + soc_bus_pkg::page_w'(i)) begin
        cs[i+1] = 1'b1;
      end
    end
    // anything unmapped lands in the data memory
    cs[0] = ~|cs[soc_bus_pkg::num_cs-1:1];
  end

  for (genvar g = 0; g < soc_bus_pkg::num_cs; g++) begin : g_fan
    assign blk[g].cs = cs[g];
    assign blk[g].rd = mem_rstrb;
    // any lane set means a write
    assign blk[g].wr = |mem_wmask;
    assign blk[g].wmask = mem_wmask;
    assign blk[g].wdata = mem_wdata;
    if (g == 0) begin : g_mem
      // word index and byte lane from the memory view
      assign blk[g].reg_sel = {addr.mem_view.index, addr.mem_view.lane};
    end else begin : g_per
      // register offset from the peripheral view
      assign blk[g].reg_sel = {{(soc_bus_pkg::sel_w - soc_bus_pkg::reg_aw){1'b0}},
                               addr.per_view.offset};
    end
  end

endmodule

//--- hw/sram_block.sv
module sram_block (
  input  logic clk,
  input  logic reset,
  periph_bus_if.target bus
);

  logic [soc_bus_pkg::data_w-1:0] mem [soc_bus_pkg::ram_words];
  logic [soc_bus_pkg::ram_aw-1:0] idx;

  // drop the byte lane bits
  assign idx = bus.reg_sel[soc_bus_pkg::sel_w-1:2];

  // byte-lane writes
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (bus.cs && bus.wmask[b]) begin
        mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

  // registered read, held until next selected read
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.rdata <= '0;
    end else if (bus.cs && bus.rd) begin
      bus.rdata <= mem[idx];
    end
  end

endmodule

//--- hw/peripheral_mult.sv
module peripheral_mult (
  input  logic clk,
  input  logic reset,
  periph_bus_if.target bus
);

  logic [soc_bus_pkg::reg_aw-1:0] offset;
  logic wr_hit;
  logic init_hit;

  // operand registers
  logic [soc_bus_pkg::op_w-1:0] op_a;
  logic [soc_bus_pkg::op_w-1:0] op_b;

  // engine state
  logic [soc_bus_pkg::data_w-1:0] product;
  logic [soc_bus_pkg::data_w-1:0] mcand;
  logic [soc_bus_pkg::op_w-1:0] mplier;
  logic [soc_bus_pkg::step_w-1:0] step;
  logic busy;
  logic done;

  assign offset = bus.reg_sel[soc_bus_pkg::reg_aw-1:0];
  assign wr_hit = bus.cs && bus.wr;
  assign init_hit = wr_hit && (offset == soc_bus_pkg::reg_init);

  // control and product
  always_ff @(posedge clk) begin
    if (reset) begin
      op_a <= '0;
      op_b <= '0;
      product <= '0;
      step <= '0;
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      if (wr_hit && offset == soc_bus_pkg::reg_op_a) begin
        op_a <= bus.wdata[soc_bus_pkg::op_w-1:0];
      end
      if (wr_hit && offset == soc_bus_pkg::reg_op_b) begin
        op_b <= bus.wdata[soc_bus_pkg::op_w-1:0];
      end
      // init also restarts a running engine
      if (init_hit) begin
        product <= '0;
        step <= '0;
        busy <= 1'b1;
        done <= 1'b0;
      end else if (busy) begin
        // add when current multiplier bit is set
        if (mplier[0]) begin
          product <= product + mcand;
        end
        step <= step + 1'b1;
        if (step == soc_bus_pkg::last_step) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // multiplicand shifts left, multiplier shifts right
  always_ff @(posedge clk) begin
    if (init_hit) begin
      mcand <= {{soc_bus_pkg::op_w{1'b0}}, op_a};
      mplier <= op_b;
    end else if (busy) begin
      mcand <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // register read port
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.rdata <= '0;
    end else if (bus.cs && bus.rd) begin
      case (offset)
        soc_bus_pkg::reg_op_a: bus.rdata <= {{soc_bus_pkg::op_w{1'b0}}, op_a};
        soc_bus_pkg::reg_op_b: bus.rdata <= {{soc_bus_pkg::op_w{1'b0}}, op_b};
        soc_bus_pkg::reg_result: bus.rdata <= product;
        soc_bus_pkg::reg_done: bus.rdata <= {{(soc_bus_pkg::data_w-1){1'b0}}, done};
        // init and unknown offsets
        default: bus.rdata <= '0;
      endcase
    end
  end

endmodule

//--- hw/read_mux.sv
module read_mux (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           rd,
  periph_bus_if.sink                     blk [soc_bus_pkg::num_cs],
  output logic [soc_bus_pkg::data_w-1:0] mem_rdata
);

  logic [soc_bus_pkg::num_cs-1:0] cs_now;
  logic [soc_bus_pkg::num_cs-1:0] cs_q;
  logic [soc_bus_pkg::data_w-1:0] data [soc_bus_pkg::num_cs];

  // flatten the interface array
  for (genvar g = 0; g < soc_bus_pkg::num_cs; g++) begin : g_tap
    assign cs_now[g] = blk[g].cs;
    assign data[g] = blk[g].rdata;
  end

  // select follows the read, lines up with the registered data
  always_ff @(posedge clk) begin
    if (reset) begin
      cs_q <= {{(soc_bus_pkg::num_cs-1){1'b0}}, 1'b1};
    end else if (rd) begin
      cs_q <= cs_now;
    end
  end

  // and-or mux, select is one-hot
  always_comb begin
    mem_rdata = '0;
    for (int i = 0; i < soc_bus_pkg::num_cs; i++) begin
      if (cs_q[i]) begin
        mem_rdata = mem_rdata | data[i];
      end
    end
  end

endmodule

//--- hw/soc_bus_top.sv
module soc_bus_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [soc_bus_pkg::addr_w-1:0] mem_addr,
  input  logic [soc_bus_pkg::data_w-1:0] mem_wdata,
  input  logic [3:0]                     mem_wmask,
  input  logic                           mem_rstrb,
  output logic [soc_bus_pkg::data_w-1:0] mem_rdata
);

  // one bus per block, memory first
  periph_bus_if blk [soc_bus_pkg::num_cs] ();

  address_decoder u_decoder (
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_rstrb (mem_rstrb),
    .blk       (blk)
  );

  sram_block u_sram (
    .clk   (clk),
    .reset (reset),
    .bus   (blk[0])
  );

  // multiplier i on select 1+i
  for (genvar g = 0; g < soc_bus_pkg::num_mult; g++) begin : g_mult
    peripheral_mult u_mult (
      .clk   (clk),
      .reset (reset),
      .bus   (blk[g+1])
    );
  end

  read_mux u_mux (
    .clk       (clk),
    .reset     (reset),
    .rd        (mem_rstrb),
    .blk       (blk),
    .mem_rdata (mem_rdata)
  );

endmodule

//--- dv/clock_gen.sv
module clock_gen (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // high for the first 3 rising edges, dropped on a falling edge
  initial begin
    reset = 1'b1;
    repeat (3) @(negedge clk);
    reset = 1'b0;
  end

endmodule

//--- dv/bus_checker.sv
module bus_checker (
  input  logic        clk,
  input  logic        check,
  input  logic [31:0] exp_val,
  input  logic [31:0] addr,
  input  logic [31:0] mem_rdata,
  input  logic        report,
  output int          pass_count,
  output int          fail_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic pend = 1'b0;
  logic [31:0] pend_exp;
  logic [31:0] pend_addr;
  logic reported = 1'b0;
  int passes = 0;
  int fails = 0;

  assign pass_count = passes;
  assign fail_count = fails;

  // capture the read request at the edge that takes it
  always @(posedge clk) begin
    pend <= check;
    pend_exp <= exp_val;
    pend_addr <= addr;
    // closing summary, once
    if (report && !reported) begin
      $display("checks: %0d run, %0d passed, %0d failed", passes + fails, passes, fails);
      reported <= 1'b1;
    end
  end

  // read data is settled by the falling edge after the strobe cycle
  always @(negedge clk) begin
    if (pend) begin
      if (mem_rdata !== pend_exp) begin
        fails++;
        $display("Error at %0t: read of %h returned %h, expected %h",
                 $time, pend_addr, mem_rdata, pend_exp);
      end else begin
        passes++;
        $display("test %0d: read of %h gave %h, ok", passes + fails, pend_addr, mem_rdata);
      end
    end
  end

endmodule

//--- dv/tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  // row kinds
  localparam logic [1:0] k_write = 2'd0;
  localparam logic [1:0] k_read = 2'd1;
  localparam logic [1:0] k_poll = 2'd2;

  typedef struct packed {
    logic [1:0] kind;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] mask;
    logic [31:0] exp_val;
  } row_t;

  logic clk;
  logic reset;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0] mem_wmask;
  logic mem_rstrb;
  logic [31:0] mem_rdata;
  logic check;
  logic [31:0] check_exp;
  logic report;
  int pass_count;
  int fail_count;
  int cycles = 0;
  int limit = 0;
  row_t rows[$];

  clock_gen clk_gen0 (.clk(clk), .reset(reset));

  soc_bus_top dut0 (
    .clk       (clk),
    .reset     (reset),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_rstrb (mem_rstrb),
    .mem_rdata (mem_rdata)
  );

  bus_checker chk0 (
    .clk        (clk),
    .check      (check),
    .exp_val    (check_exp),
    .addr       (mem_addr),
    .mem_rdata  (mem_rdata),
    .report     (report),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  // page 0x40 + m, register offset in the low bits
  function automatic logic [31:0] mult_reg(input int m, input logic [4:0] off);
    return {16'h0040 + 16'(m), 11'd0, off};
  endfunction

  function automatic logic [31:0] product_of(input logic [15:0] a, input logic [15:0] b);
    return {16'h0, a} * {16'h0, b};
  endfunction

  task automatic add_row(input logic [1:0] kind, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] mask,
                         input logic [31:0] exp_val);
    rows.push_back(row_t'{kind, addr, wdata, mask, exp_val});
  endtask

  // operands with junk upper half, init, poll done, read result
  task automatic add_product(input int m, input logic [15:0] a, input logic [15:0] b);
    add_row(k_write, mult_reg(m, 5'd0), {16'hffff, a}, 4'hf, 32'd0);
    add_row(k_write, mult_reg(m, 5'd4), {16'hffff, b}, 4'hf, 32'd0);
    add_row(k_write, mult_reg(m, 5'd8), 32'd1, 4'hf, 32'd0);
    add_row(k_poll, mult_reg(m, 5'd16), 32'd0, 4'h0, 32'd1);
    add_row(k_read, mult_reg(m, 5'd12), 32'd0, 4'h0, product_of(a, b));
  endtask

  // one row per call, starting and ending on a falling edge
  task automatic run_row(input row_t r);
    mem_addr = r.addr;
    mem_wdata = r.wdata;
    mem_wmask = (r.kind == k_write) ? r.mask : 4'h0;
    mem_rstrb = (r.kind != k_write);
    check = (r.kind == k_read);
    check_exp = r.exp_val;
    @(negedge clk);
    // strobe stays up, each cycle re-reads done
    while (r.kind == k_poll && mem_rdata !== r.exp_val) begin
      @(negedge clk);
    end
  endtask

  initial begin
    logic [15:0] ra;
    logic [15:0] rb;
    int unsigned seed_ret;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wmask = '0;
    mem_rstrb = 1'b0;
    check = 1'b0;
    check_exp = '0;
    report = 1'b0;
    seed_ret = $urandom(32'hce473e15);
    // memory words and single byte lanes
    add_row(k_write, 32'h0000_0000, 32'h1122_3344, 4'hf, 32'd0);
    add_row(k_write, 32'h0000_0004, 32'hcafe_f00d, 4'hf, 32'd0);
    add_row(k_read, 32'h0000_0000, 32'd0, 4'h0, 32'h1122_3344);
    add_row(k_read, 32'h0000_0004, 32'd0, 4'h0, 32'hcafe_f00d);
    add_row(k_write, 32'h0000_0000, 32'haaaa_aaaa, 4'b0010, 32'd0);
    add_row(k_write, 32'h0000_0004, 32'h5555_5555, 4'b1000, 32'd0);
    add_row(k_read, 32'h0000_0000, 32'd0, 4'h0, 32'h1122_aa44);
    add_row(k_read, 32'h0000_0004, 32'd0, 4'h0, 32'h55fe_f00d);
    // unmapped page 0x50 lands in memory, index wraps at 256 words
    add_row(k_write, 32'h0050_000c, 32'h0bad_beef, 4'hf, 32'd0);
    add_row(k_read, 32'h0000_000c, 32'd0, 4'h0, 32'h0bad_beef);
    add_row(k_write, 32'h0000_0414, 32'h1357_9bdf, 4'hf, 32'd0);
    add_row(k_read, 32'h0050_0014, 32'd0, 4'h0, 32'h1357_9bdf);
    // done low after reset, operands keep low 16 bits
    for (int m = 0; m < 4; m++) begin
      add_row(k_read, mult_reg(m, 5'd16), 32'd0, 4'h0, 32'd0);
      add_row(k_write, mult_reg(m, 5'd0), 32'hdead_1230 + 32'(m), 4'hf, 32'd0);
      add_row(k_write, mult_reg(m, 5'd4), 32'hbeef_8760 + 32'(m), 4'hf, 32'd0);
      add_row(k_read, mult_reg(m, 5'd0), 32'd0, 4'h0, 32'h0000_1230 + 32'(m));
      add_row(k_read, mult_reg(m, 5'd4), 32'd0, 4'h0, 32'h0000_8760 + 32'(m));
    end
    // corner pairs, then random pairs
    for (int m = 0; m < 4; m++) begin
      add_product(m, 16'h0000, 16'h1234);
      add_product(m, 16'h0001, 16'habcd);
      add_product(m, 16'hffff, 16'hffff);
      for (int k = 0; k < 2; k++) begin
        ra = 16'($urandom);
        rb = 16'($urandom);
        add_product(m, ra, rb);
      end
    end
    // all four engines in flight together
    for (int m = 0; m < 4; m++) begin
      add_row(k_write, mult_reg(m, 5'd0), 32'(1000 + 7 * m), 4'hf, 32'd0);
      add_row(k_write, mult_reg(m, 5'd4), 32'(300 + 11 * m), 4'hf, 32'd0);
    end
    for (int m = 0; m < 4; m++) begin
      add_row(k_write, mult_reg(m, 5'd8), 32'd1, 4'hf, 32'd0);
    end
    for (int m = 0; m < 4; m++) begin
      add_row(k_poll, mult_reg(m, 5'd16), 32'd0, 4'h0, 32'd1);
    end
    // back-to-back reads, memory and multipliers interleaved
    add_row(k_read, 32'h0000_0000, 32'd0, 4'h0, 32'h1122_aa44);
    add_row(k_read, mult_reg(0, 5'd12), 32'd0, 4'h0, product_of(16'd1000, 16'd300));
    add_row(k_read, 32'h0000_0004, 32'd0, 4'h0, 32'h55fe_f00d);
    add_row(k_read, mult_reg(1, 5'd12), 32'd0, 4'h0, product_of(16'd1007, 16'd311));
    add_row(k_read, 32'h0000_000c, 32'd0, 4'h0, 32'h0bad_beef);
    add_row(k_read, mult_reg(2, 5'd12), 32'd0, 4'h0, product_of(16'd1014, 16'd322));
    add_row(k_read, 32'h0000_0014, 32'd0, 4'h0, 32'h1357_9bdf);
    add_row(k_read, mult_reg(3, 5'd12), 32'd0, 4'h0, product_of(16'd1021, 16'd333));
    // restart mid-run, result follows the last init
    add_row(k_write, mult_reg(2, 5'd0), 32'h0000_00ff, 4'hf, 32'd0);
    add_row(k_write, mult_reg(2, 5'd4), 32'h0000_0f0f, 4'hf, 32'd0);
    add_row(k_write, mult_reg(2, 5'd8), 32'd1, 4'hf, 32'd0);
    add_row(k_read, mult_reg(2, 5'd16), 32'd0, 4'h0, 32'd0);
    add_row(k_write, mult_reg(2, 5'd0), 32'h0000_1001, 4'hf, 32'd0);
    add_row(k_write, mult_reg(2, 5'd8), 32'd1, 4'hf, 32'd0);
    // first run would have finished by now, the restarted one not yet
    for (int k = 0; k < 14; k++) begin
      add_row(k_read, mult_reg(2, 5'd0), 32'd0, 4'h0, 32'h0000_1001);
    end
    add_row(k_read, mult_reg(2, 5'd16), 32'd0, 4'h0, 32'd0);
    add_row(k_poll, mult_reg(2, 5'd16), 32'd0, 4'h0, 32'd1);
    add_row(k_read, mult_reg(2, 5'd12), 32'd0, 4'h0, product_of(16'h1001, 16'h0f0f));
    limit = rows.size() * 40 + 20;
    wait (reset == 1'b0);
    @(negedge clk);
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    // bus idle, let the last check land
    mem_wmask = 4'h0;
    mem_rstrb = 1'b0;
    check = 1'b0;
    @(negedge clk);
    report = 1'b1;
    @(negedge clk);
    @(negedge clk);
    if (fail_count == 0 && pass_count > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // cycle budget from the table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("run timed out after %0d cycles without finishing the table", cycles);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

//--- soc_bus.f
hw/soc_bus_pkg.sv
hw/periph_bus_if.sv
hw/address_decoder.sv
hw/sram_block.sv
hw/peripheral_mult.sv
hw/read_mux.sv
hw/soc_bus_top.sv
dv/clock_gen.sv
dv/bus_checker.sv
dv/tb_top.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_top -f soc_bus.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF 'All tests passed!'; then
  exit 0
fi
exit 1
